//--- src/analogizer_pkg.sv
// Shared widths, mode codes, path latency and YPbPr coefficients; referenced by scoped names
package analogizer_pkg;

	// Channel and control widths
	localparam int COLOR_W = 8;             // Incoming colour channel
	localparam int DAC_W   = 6;             // Cartridge DAC channel, top bits of a colour
	localparam int MODE_W  = 4;             // Analog video type select

	// Register stages through either encoder
	localparam int PATH_LATENCY = 3;

	// Low three bits of the analog video type, bit 3 is don't care
	localparam logic [2:0] MODE_RGBS  = 3'd0; // Separate composite sync on HS pin
	localparam logic [2:0] MODE_RGSB  = 3'd1; // Sync on green through the SOG switch
	localparam logic [2:0] MODE_YPBPR = 3'd2; // Component, sync rides on Y

	// Luma row, weights sum to 256
	localparam logic signed [8:0] Y_KR  = 9'sd77;
	localparam logic signed [8:0] Y_KG  = 9'sd150;
	localparam logic signed [8:0] Y_KB  = 9'sd29;

	// Blue difference row
	localparam logic signed [8:0] PB_KR = -9'sd43;
	localparam logic signed [8:0] PB_KG = -9'sd85;
	localparam logic signed [8:0] PB_KB = 9'sd128;

	// Red difference row
	localparam logic signed [8:0] PR_KR = 9'sd128;
	localparam logic signed [8:0] PR_KG = -9'sd107;
	localparam logic signed [8:0] PR_KB = -9'sd21;

	localparam int CHROMA_OFFSET = 128;     // Mid-scale for Pb and Pr

	typedef logic [COLOR_W-1:0] color_t;
	typedef logic [DAC_W-1:0]   dac_t;
	typedef logic [MODE_W-1:0]  mode_t;

endpackage

//--- src/video_if.sv
// Pixel stream and DAC channel bundles that connect the encoders to the mode combiner
`timescale 1ns/1ps

// One pixel per video_clk with its sync and blanking, no handshake
interface video_if;
	analogizer_pkg::color_t r;
	analogizer_pkg::color_t g;
	analogizer_pkg::color_t b;
	logic hsync;            // Raw horizontal sync
	logic vsync;            // Raw vertical sync
	logic csync;            // Composite sync from the core
	logic blank_n;          // Low during blanking

	modport src (
		output r, g, b,
		output hsync, vsync, csync, blank_n
	);

	modport snk (
		input r, g, b,
		input hsync, vsync, csync, blank_n
	);
endinterface

// Six bit DAC word plus the two sync pins and blank of the video DAC
interface dac_if;
	analogizer_pkg::dac_t r;
	analogizer_pkg::dac_t g;
	analogizer_pkg::dac_t b;
	logic hs;               // Meaning depends on the producer
	logic vs;
	logic blank_n;

	modport src (
		output r, g, b,
		output hs, vs, blank_n
	);

	modport snk (
		input r, g, b,
		input hs, vs, blank_n
	);
endinterface

//--- src/rgb_path.sv
// Blank-masked RGB encoder feeding the RGBS and RGsB modes of the mode combiner
`timescale 1ns/1ps

module rgb_path (
	input  logic i_video_clk,
	input  logic i_rst_n,
	video_if.snk vid,
	dac_if.src   o_rgb
);
	// Colour delay lines, stage 0 holds the masked value
	analogizer_pkg::dac_t r_q [analogizer_pkg::PATH_LATENCY];
	analogizer_pkg::dac_t g_q [analogizer_pkg::PATH_LATENCY];
	analogizer_pkg::dac_t b_q [analogizer_pkg::PATH_LATENCY];

	logic [analogizer_pkg::PATH_LATENCY-1:0] cs_q;  // Composite sync
	logic [analogizer_pkg::PATH_LATENCY-1:0] hs_q;  // Raw hsync for the default mode
	logic [analogizer_pkg::PATH_LATENCY-1:0] bl_q;  // Blank, active low

	// Mask during blanking, keep the top DAC bits
	always_ff @(posedge i_video_clk) begin
		r_q[0] <= vid.r[analogizer_pkg::COLOR_W-1 -: analogizer_pkg::DAC_W]
			& {analogizer_pkg::DAC_W{vid.blank_n}};
		g_q[0] <= vid.g[analogizer_pkg::COLOR_W-1 -: analogizer_pkg::DAC_W]
			& {analogizer_pkg::DAC_W{vid.blank_n}};
		b_q[0] <= vid.b[analogizer_pkg::COLOR_W-1 -: analogizer_pkg::DAC_W]
			& {analogizer_pkg::DAC_W{vid.blank_n}};
		for (int i = 1; i < analogizer_pkg::PATH_LATENCY; i++) begin
			r_q[i] <= r_q[i-1];
			g_q[i] <= g_q[i-1];
			b_q[i] <= b_q[i-1];
		end
	end

	// Syncs idle high and blank asserted out of reset
	always_ff @(posedge i_video_clk) begin
		if (!i_rst_n) begin
			cs_q <= '1;
			hs_q <= '1;
			bl_q <= '0;
		end else begin
			cs_q <= {cs_q[analogizer_pkg::PATH_LATENCY-2:0], vid.csync};
			hs_q <= {hs_q[analogizer_pkg::PATH_LATENCY-2:0], vid.hsync};
			bl_q <= {bl_q[analogizer_pkg::PATH_LATENCY-2:0], vid.blank_n};
		end
	end

	assign o_rgb.r = r_q[analogizer_pkg::PATH_LATENCY-1];
	assign o_rgb.g = g_q[analogizer_pkg::PATH_LATENCY-1];
	assign o_rgb.b = b_q[analogizer_pkg::PATH_LATENCY-1];
	assign o_rgb.hs = cs_q[analogizer_pkg::PATH_LATENCY-1];      // Csync, routed per mode later
	assign o_rgb.vs = hs_q[analogizer_pkg::PATH_LATENCY-1];      // Raw hsync rides here
	assign o_rgb.blank_n = bl_q[analogizer_pkg::PATH_LATENCY-1];

	// A blanked pixel leaves the path black
	a_blank_black: assert property (@(posedge i_video_clk) disable iff (!i_rst_n)
		!vid.blank_n |-> ##3 (o_rgb.r == '0 && o_rgb.g == '0 && o_rgb.b == '0))
		else $error("rgb_path: colour leaked through blanking");

endmodule

//--- src/ypbpr_encoder.sv
// RGB to YPbPr converter for component output, composite sync delayed to match on vs
`timescale 1ns/1ps

module ypbpr_encoder (
	input  logic i_video_clk,
	input  logic i_rst_n,
	video_if.snk vid,
	dac_if.src   o_ypbpr
);
	typedef logic signed [17:0] prod_t;  // Colour times coefficient
	typedef logic signed [19:0] sum_t;   // Row sum, no overflow for full white
	typedef logic signed [11:0] chan_t;  // Scaled channel before the clamp

	analogizer_pkg::color_t r_m, g_m, b_m;

	prod_t y_p_q [3];   // Products, one per colour
	prod_t pb_p_q [3];
	prod_t pr_p_q [3];

	sum_t  y_sum, pb_sum, pr_sum;
	chan_t y_q, pb_q, pr_q;

	logic [analogizer_pkg::PATH_LATENCY-1:0] cs_q;   // Csync delay, matches the colour stages
	logic [analogizer_pkg::PATH_LATENCY-1:0] vld_q;  // Pipeline filled since reset

	// Clamp to 0..255 then keep the DAC bits
	function automatic analogizer_pkg::dac_t clamp_top(input chan_t v);
		analogizer_pkg::color_t c;
		if (v < 0) begin
			c = '0;
		end else if (v > 255) begin
			c = '1;
		end else begin
			c = v[analogizer_pkg::COLOR_W-1:0];
		end
		return c[analogizer_pkg::COLOR_W-1 -: analogizer_pkg::DAC_W];
	endfunction

	// Force black while blanked
	assign r_m = vid.r & {analogizer_pkg::COLOR_W{vid.blank_n}};
	assign g_m = vid.g & {analogizer_pkg::COLOR_W{vid.blank_n}};
	assign b_m = vid.b & {analogizer_pkg::COLOR_W{vid.blank_n}};

	// Stage 1, nine products
	always_ff @(posedge i_video_clk) begin
		y_p_q[0]  <= $signed({1'b0, r_m}) * analogizer_pkg::Y_KR;
		y_p_q[1]  <= $signed({1'b0, g_m}) * analogizer_pkg::Y_KG;
		y_p_q[2]  <= $signed({1'b0, b_m}) * analogizer_pkg::Y_KB;
		pb_p_q[0] <= $signed({1'b0, r_m}) * analogizer_pkg::PB_KR;
		pb_p_q[1] <= $signed({1'b0, g_m}) * analogizer_pkg::PB_KG;
		pb_p_q[2] <= $signed({1'b0, b_m}) * analogizer_pkg::PB_KB;
		pr_p_q[0] <= $signed({1'b0, r_m}) * analogizer_pkg::PR_KR;
		pr_p_q[1] <= $signed({1'b0, g_m}) * analogizer_pkg::PR_KG;
		pr_p_q[2] <= $signed({1'b0, b_m}) * analogizer_pkg::PR_KB;
	end

	// Row sums
	assign y_sum  = sum_t'(y_p_q[0]) + sum_t'(y_p_q[1]) + sum_t'(y_p_q[2]);
	assign pb_sum = sum_t'(pb_p_q[0]) + sum_t'(pb_p_q[1]) + sum_t'(pb_p_q[2]);
	assign pr_sum = sum_t'(pr_p_q[0]) + sum_t'(pr_p_q[1]) + sum_t'(pr_p_q[2]);

	// Stage 2, divide by 256, chroma lifted to mid-scale
	always_ff @(posedge i_video_clk) begin
		y_q  <= chan_t'(y_sum >>> 8);
		pb_q <= chan_t'(pb_sum >>> 8) + chan_t'(analogizer_pkg::CHROMA_OFFSET);
		pr_q <= chan_t'(pr_sum >>> 8) + chan_t'(analogizer_pkg::CHROMA_OFFSET);
	end

	// Stage 3, clamp and truncate, Pr on R and Pb on B
	always_ff @(posedge i_video_clk) begin
		o_ypbpr.r <= clamp_top(pr_q);
		o_ypbpr.g <= clamp_top(y_q);
		o_ypbpr.b <= clamp_top(pb_q);
	end

	always_ff @(posedge i_video_clk) begin
		if (!i_rst_n) begin
			cs_q  <= '1;  // Sync idles high
			vld_q <= '0;
		end else begin
			cs_q  <= {cs_q[analogizer_pkg::PATH_LATENCY-2:0], vid.csync};
			vld_q <= {vld_q[analogizer_pkg::PATH_LATENCY-2:0], 1'b1};
		end
	end

	assign o_ypbpr.hs = 1'b1;
	assign o_ypbpr.vs = cs_q[analogizer_pkg::PATH_LATENCY-1];  // Sync on Y via SOG
	assign o_ypbpr.blank_n = 1'b1;  // DAC blank held off, black level comes from the data

	// Sync and a blanked pixel must leave the path on the same cycle
	a_sync_aligned: assert property (@(posedge i_video_clk) disable iff (!i_rst_n)
		vld_q[analogizer_pkg::PATH_LATENCY-1] |->
			(o_ypbpr.vs == $past(vid.csync, analogizer_pkg::PATH_LATENCY)) &&
			($past(vid.blank_n, analogizer_pkg::PATH_LATENCY) ||
			 (o_ypbpr.g == '0 &&
			  o_ypbpr.b == analogizer_pkg::dac_t'(analogizer_pkg::CHROMA_OFFSET >> 2) &&
			  o_ypbpr.r == analogizer_pkg::dac_t'(analogizer_pkg::CHROMA_OFFSET >> 2))))
		else $error("ypbpr_encoder: sync and colour out of step");

endmodule

//--- src/video_mode_mux.sv
// Mode combiner that picks RGBS, RGsB, YPbPr or the default output and registers the DAC word
`timescale 1ns/1ps

module video_mode_mux (
	input  logic                  i_video_clk,
	input  logic                  i_rst_n,
	input  logic                  i_ena,
	input  analogizer_pkg::mode_t i_mode,
	dac_if.snk                    i_rgb,
	dac_if.snk                    i_ypbpr,
	dac_if.src                    o_dac,
	output logic                  o_drive
);
	// Mode and enable follow their pixel through the encoders
	analogizer_pkg::mode_t mode_q [analogizer_pkg::PATH_LATENCY];
	logic [analogizer_pkg::PATH_LATENCY-1:0] ena_q;

	analogizer_pkg::mode_t mode_d;
	analogizer_pkg::dac_t r_sel, g_sel, b_sel;
	logic hs_sel, vs_sel, bl_sel;

	always_ff @(posedge i_video_clk) begin
		if (!i_rst_n) begin
			for (int i = 0; i < analogizer_pkg::PATH_LATENCY; i++) begin
				mode_q[i] <= '0;
			end
			ena_q <= '0;  // Output stays off until a full pixel has passed
		end else begin
			mode_q[0] <= i_mode;
			for (int i = 1; i < analogizer_pkg::PATH_LATENCY; i++) begin
				mode_q[i] <= mode_q[i-1];
			end
			ena_q <= {ena_q[analogizer_pkg::PATH_LATENCY-2:0], i_ena};
		end
	end

	assign mode_d = mode_q[analogizer_pkg::PATH_LATENCY-1];

	// Bit 3 of the mode ignored
	always_comb begin
		r_sel  = i_rgb.r;
		g_sel  = i_rgb.g;
		b_sel  = i_rgb.b;
		bl_sel = i_rgb.blank_n;
		case (mode_d[2:0])
			analogizer_pkg::MODE_RGBS: begin
				hs_sel = i_rgb.hs;  // Csync on the HS pin
				vs_sel = 1'b1;
			end
			analogizer_pkg::MODE_RGSB: begin
				hs_sel = 1'b1;
				vs_sel = i_rgb.hs;  // Csync to the DAC sync pin
			end
			analogizer_pkg::MODE_YPBPR: begin
				r_sel  = i_ypbpr.r;
				g_sel  = i_ypbpr.g;
				b_sel  = i_ypbpr.b;
				hs_sel = i_ypbpr.hs;
				vs_sel = i_ypbpr.vs;
				bl_sel = i_ypbpr.blank_n;
			end
			default: begin
				// Unsupported modes, black with raw hsync
				r_sel  = '0;
				g_sel  = '0;
				b_sel  = '0;
				hs_sel = i_rgb.vs;
				vs_sel = 1'b1;
			end
		endcase
	end

	// Output register, cleared while off
	always_ff @(posedge i_video_clk) begin
		if (!i_rst_n || !ena_q[analogizer_pkg::PATH_LATENCY-1]) begin
			o_dac.r       <= '0;
			o_dac.g       <= '0;
			o_dac.b       <= '0;
			o_dac.hs      <= 1'b0;
			o_dac.vs      <= 1'b0;
			o_dac.blank_n <= 1'b0;
			o_drive       <= 1'b0;
		end else begin
			o_dac.r       <= r_sel;
			o_dac.g       <= g_sel;
			o_dac.b       <= b_sel;
			o_dac.hs      <= hs_sel;
			o_dac.vs      <= vs_sel;
			o_dac.blank_n <= bl_sel;
			o_drive       <= 1'b1;
		end
	end

	// Enable low with its pixel leaves the pins released and the word black
	a_off_zero: assert property (@(posedge i_video_clk) disable iff (!i_rst_n)
		!$past(i_ena, analogizer_pkg::PATH_LATENCY + 1) |->
			(!o_drive && o_dac.r == '0 && o_dac.g == '0 && o_dac.b == '0 &&
			 !o_dac.hs && !o_dac.vs && !o_dac.blank_n))
		else $error("video_mode_mux: DAC word not cleared while undriven");

endmodule

//--- src/analogizer_video_top.sv
// Top of the cartridge-port video adapter; instantiate in the core and wire the banks to the port
`timescale 1ns/1ps

module analogizer_video_top (
	input  logic                   video_clk,
	input  logic                   i_rst_n,
	input  logic                   i_ena,         // Low releases the cartridge pins
	input  analogizer_pkg::mode_t  i_video_type,  // Analog video type select
	input  analogizer_pkg::color_t i_r,
	input  analogizer_pkg::color_t i_g,
	input  analogizer_pkg::color_t i_b,
	input  logic                   i_hsync,
	input  logic                   i_vsync,
	input  logic                   i_csync,
	input  logic                   i_blank_n,
	output logic [7:0]             o_bank1,
	output logic [7:0]             o_bank2,
	output logic [7:0]             o_bank3,
	output logic                   o_bank1_dir,   // 1 drives the bank
	output logic                   o_bank2_dir,
	output logic                   o_bank3_dir
);
	video_if vid ();
	dac_if   rgb_out ();
	dac_if   ypbpr_out ();
	dac_if   dac_out ();    // Selected word from the combiner

	logic drive;

	// Incoming pixel stream
	assign vid.r       = i_r;
	assign vid.g       = i_g;
	assign vid.b       = i_b;
	assign vid.hsync   = i_hsync;
	assign vid.vsync   = i_vsync;
	assign vid.csync   = i_csync;
	assign vid.blank_n = i_blank_n;

	rgb_path u_rgb (
		.i_video_clk (video_clk),
		.i_rst_n     (i_rst_n),
		.vid         (vid),
		.o_rgb       (rgb_out)
	);

	ypbpr_encoder u_ypbpr (
		.i_video_clk (video_clk),
		.i_rst_n     (i_rst_n),
		.vid         (vid),
		.o_ypbpr     (ypbpr_out)
	);

	video_mode_mux u_mux (
		.i_video_clk (video_clk),
		.i_rst_n     (i_rst_n),
		.i_ena       (i_ena),
		.i_mode      (i_video_type),
		.i_rgb       (rgb_out),
		.i_ypbpr     (ypbpr_out),
		.o_dac       (dac_out),
		.o_drive     (drive)
	);

	// Bank3: R then the two DAC sync pins
	assign o_bank3 = {dac_out.r, dac_out.hs, dac_out.vs};
	// Bank2: B lsb, blank, G
	assign o_bank2 = {dac_out.b[0], dac_out.blank_n, dac_out.g};
	// Bank1: upper pins unused, pixel clock to the DAC, B upper bits
	assign o_bank1 = {2'b00, video_clk & drive, dac_out.b[analogizer_pkg::DAC_W-1:1]};

	assign o_bank1_dir = drive;
	assign o_bank2_dir = drive;
	assign o_bank3_dir = drive;

endmodule

//--- sim/tb_analogizer.sv
// Self-checking testbench for analogizer_video_top; run through run_sim.sh or any tool on filelist.f
`timescale 1ns/1ps

module tb_analogizer;
	localparam int CLK_PERIOD   = 100;   // ns
	localparam int RESET_CYCLES = 5;
	localparam int OUT_LATENCY  = 4;     // Drive edge to stable bank outputs
	localparam int RGB_CYCLES   = 200;
	localparam int YPBPR_CYCLES = 200;
	localparam int DEF_CYCLES   = 16;    // Per unsupported mode code
	localparam int MIX_CYCLES   = 200;
	localparam int ENA_CYCLES   = 120;
	localparam int FLUSH_CYCLES = 8;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * RGB_CYCLES + 6 + YPBPR_CYCLES
		+ 10 * DEF_CYCLES + MIX_CYCLES + ENA_CYCLES + FLUSH_CYCLES;

	// Expected pins for one pixel
	typedef struct packed {
		logic [7:0] bank1;
		logic [7:0] bank2;
		logic [7:0] bank3;
		logic       dir;
	} banks_t;

	logic video_clk;
	logic i_rst_n;
	logic i_ena;
	analogizer_pkg::mode_t  i_video_type;
	analogizer_pkg::color_t i_r, i_g, i_b;
	logic i_hsync, i_vsync, i_csync, i_blank_n;
	logic [7:0] o_bank1, o_bank2, o_bank3;
	logic o_bank1_dir, o_bank2_dir, o_bank3_dir;

	banks_t exp_q [$];       // One entry per drive edge, oldest first
	int n_pushed  = 0;
	int n_checked = 0;

	analogizer_video_top DUT (
		.video_clk    (video_clk),
		.i_rst_n      (i_rst_n),
		.i_ena        (i_ena),
		.i_video_type (i_video_type),
		.i_r          (i_r),
		.i_g          (i_g),
		.i_b          (i_b),
		.i_hsync      (i_hsync),
		.i_vsync      (i_vsync),
		.i_csync      (i_csync),
		.i_blank_n    (i_blank_n),
		.o_bank1      (o_bank1),
		.o_bank2      (o_bank2),
		.o_bank3      (o_bank3),
		.o_bank1_dir  (o_bank1_dir),
		.o_bank2_dir  (o_bank2_dir),
		.o_bank3_dir  (o_bank3_dir)
	);

	initial begin
		video_clk = 1'b0;
		forever #(CLK_PERIOD / 2) video_clk = ~video_clk;
	end

	// One colour-difference row, weights scaled by 256, floor division
	function automatic int scale_row(input int r, g, b, input int kr, kg, kb);
		return (r * kr + g * kg + b * kb) >>> 8;
	endfunction

	// Clamp to the 8 bit range then keep the DAC bits
	function automatic analogizer_pkg::dac_t to_dac(input int v);
		int c;
		c = (v < 0) ? 0 : ((v > 255) ? 255 : v);
		return analogizer_pkg::dac_t'(c >>> 2);
	endfunction

	// Bank words the adapter should show for one pixel
	function automatic banks_t expected_banks(
		input analogizer_pkg::color_t r, g, b,
		input logic hs, cs, bl,
		input analogizer_pkg::mode_t mode,
		input logic ena
	);
		banks_t e;
		analogizer_pkg::color_t rm, gm, bm;
		analogizer_pkg::dac_t er, eg, eb;
		logic ehs, evs, ebl;
		rm  = bl ? r : 8'd0;    // Black while blanked
		gm  = bl ? g : 8'd0;
		bm  = bl ? b : 8'd0;
		er  = rm[7:2];
		eg  = gm[7:2];
		eb  = bm[7:2];
		ebl = bl;
		case (mode[2:0])        // Bit 3 is don't care
			analogizer_pkg::MODE_RGBS: begin
				ehs = cs;
				evs = 1'b1;
			end
			analogizer_pkg::MODE_RGSB: begin
				ehs = 1'b1;
				evs = cs;
			end
			analogizer_pkg::MODE_YPBPR: begin
				er  = to_dac(scale_row(int'(rm), int'(gm), int'(bm),
					int'(analogizer_pkg::PR_KR), int'(analogizer_pkg::PR_KG),
					int'(analogizer_pkg::PR_KB)) + analogizer_pkg::CHROMA_OFFSET);
				eg  = to_dac(scale_row(int'(rm), int'(gm), int'(bm),
					int'(analogizer_pkg::Y_KR), int'(analogizer_pkg::Y_KG),
					int'(analogizer_pkg::Y_KB)));
				eb  = to_dac(scale_row(int'(rm), int'(gm), int'(bm),
					int'(analogizer_pkg::PB_KR), int'(analogizer_pkg::PB_KG),
					int'(analogizer_pkg::PB_KB)) + analogizer_pkg::CHROMA_OFFSET);
				ehs = 1'b1;
				evs = cs;           // Sync on Y
				ebl = 1'b1;
			end
			default: begin
				er  = '0;
				eg  = '0;
				eb  = '0;
				ehs = hs;           // Raw hsync only
				evs = 1'b1;
			end
		endcase
		if (!ena) begin
			er  = '0;
			eg  = '0;
			eb  = '0;
			ehs = 1'b0;
			evs = 1'b0;
			ebl = 1'b0;
		end
		e.bank3 = {er, ehs, evs};
		e.bank2 = {eb[0], ebl, eg};
		e.bank1 = {3'b000, eb[5:1]};  // Pixel clock pin left out of the compare
		e.dir   = ena;
		return e;
	endfunction

	task automatic check_bank(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "Bank output mismatch");
		end
	endtask

	task automatic check_dir(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, name, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "Direction output mismatch");
		end
	endtask

	// Drive one pixel on the next rising edge and queue its expected banks
	task automatic drive_pixel(
		input logic rst_n, ena,
		input analogizer_pkg::mode_t mode,
		input analogizer_pkg::color_t r, g, b,
		input logic hs, cs, bl
	);
		@(posedge video_clk);
		i_rst_n      <= rst_n;
		i_ena        <= ena;
		i_video_type <= mode;
		i_r          <= r;
		i_g          <= g;
		i_b          <= b;
		i_hsync      <= hs;
		i_vsync      <= 1'($urandom);   // Not used by any mode
		i_csync      <= cs;
		i_blank_n    <= bl;
		exp_q.push_back(expected_banks(r, g, b, hs, cs, bl, mode, ena && rst_n));
		n_pushed++;
	endtask

	// Random pixel and syncs, blanked about once in blank_rate cycles
	task automatic drive_random(input logic ena, input analogizer_pkg::mode_t mode,
		input int blank_rate);
		logic bl;
		bl = ($urandom_range(blank_rate - 1) != 0);
		drive_pixel(1'b1, ena, mode, analogizer_pkg::color_t'($urandom),
			analogizer_pkg::color_t'($urandom), analogizer_pkg::color_t'($urandom),
			1'($urandom), 1'($urandom), bl);
	endtask

	// Output of drive k is stable after edge k+4, so compare on the falling edge
	always @(negedge video_clk) begin : compare
		banks_t e;
		if (exp_q.size() > OUT_LATENCY) begin
			e = exp_q.pop_front();
			check_bank("o_bank1", o_bank1 & 8'hDF, e.bank1);   // Bit 5 is the gated clock
			check_bank("o_bank2", o_bank2, e.bank2);
			check_bank("o_bank3", o_bank3, e.bank3);
			check_dir("o_bank1_dir", o_bank1_dir, e.dir);
			check_dir("o_bank2_dir", o_bank2_dir, e.dir);
			check_dir("o_bank3_dir", o_bank3_dir, e.dir);
			n_checked++;
		end
	end

	initial begin : watchdog
		#((TOTAL_CYCLES + 100) * CLK_PERIOD);
		$display("RESULT: FAIL");
		$fatal(1, "Timeout, the stimulus did not finish in time");
	end

	initial begin : stimulus
		void'($urandom(73));
		// Idle inputs, reset held, sampled at the first edge
		i_rst_n      = 1'b0;
		i_ena        = 1'b1;
		i_video_type = '0;
		i_r          = '0;
		i_g          = '0;
		i_b          = '0;
		i_hsync      = 1'b1;
		i_vsync      = 1'b1;
		i_csync      = 1'b1;
		i_blank_n    = 1'b0;
		exp_q.push_back(expected_banks('0, '0, '0, 1'b1, 1'b1, 1'b0, '0, 1'b0));
		n_pushed++;
		repeat (RESET_CYCLES - 1) begin
			drive_pixel(1'b0, 1'b1, '0, '0, '0, '0, 1'b1, 1'b1, 1'b0);
		end

		// RGBS then RGsB, codes 0/8 and 1/9
		repeat (RGB_CYCLES) drive_random(1'b1, {1'($urandom), analogizer_pkg::MODE_RGBS}, 4);
		repeat (RGB_CYCLES) drive_random(1'b1, {1'($urandom), analogizer_pkg::MODE_RGSB}, 4);

		// YPbPr corner colours, then random
		drive_pixel(1'b1, 1'b1, 4'h2, 8'd0, 8'd0, 8'd0, 1'b1, 1'b0, 1'b1);
		drive_pixel(1'b1, 1'b1, 4'h2, 8'd255, 8'd255, 8'd255, 1'b1, 1'b1, 1'b1);
		drive_pixel(1'b1, 1'b1, 4'hA, 8'd255, 8'd0, 8'd0, 1'b0, 1'b1, 1'b1);
		drive_pixel(1'b1, 1'b1, 4'h2, 8'd0, 8'd255, 8'd0, 1'b1, 1'b0, 1'b1);
		drive_pixel(1'b1, 1'b1, 4'hA, 8'd0, 8'd0, 8'd255, 1'b1, 1'b1, 1'b1);
		drive_pixel(1'b1, 1'b1, 4'h2, 8'd255, 8'd255, 8'd255, 1'b0, 1'b0, 1'b0);  // Blanked white
		repeat (YPBPR_CYCLES) drive_random(1'b1, {1'($urandom), analogizer_pkg::MODE_YPBPR}, 8);

		// Unsupported codes 3-7 and B-F
		for (int c = 0; c < 16; c++) begin
			if ((c % 8) >= 3) begin
				repeat (DEF_CYCLES) drive_random(1'b1, analogizer_pkg::mode_t'(c), 4);
			end
		end

		// Mode changes every pixel, it must travel with its data
		repeat (MIX_CYCLES) drive_random(1'b1, analogizer_pkg::mode_t'($urandom), 4);

		// Enable off, back on, then toggling
		repeat (10) drive_random(1'b0, analogizer_pkg::mode_t'($urandom), 4);
		repeat (10) drive_random(1'b1, analogizer_pkg::mode_t'($urandom), 4);
		repeat (ENA_CYCLES - 20) drive_random(1'($urandom), analogizer_pkg::mode_t'($urandom), 4);

		repeat (FLUSH_CYCLES) drive_random(1'b1, analogizer_pkg::MODE_RGBS, 4);
		@(posedge video_clk);   // Last falling-edge compare done

		if (n_checked > 0 && n_checked + OUT_LATENCY == n_pushed) begin
			$display("RESULT: PASS");
			$finish;
		end else begin
			$display("Only %0d of %0d pixels were compared", n_checked, n_pushed - OUT_LATENCY);
			$display("RESULT: FAIL");
			$fatal(1, "Compare count does not match the stimulus");
		end
	end

endmodule

//--- filelist.f
src/analogizer_pkg.sv
src/video_if.sv
src/rgb_path.sv
src/ypbpr_encoder.sv
src/video_mode_mux.sv
src/analogizer_video_top.sv
sim/tb_analogizer.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the test result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_analogizer \
	--Mdir obj_dir \
	-f filelist.f \
	&& ./obj_dir/Vtb_analogizer \
	|| { echo "Simulation build or run failed" >&2; exit 1; }

exit 0
